// ==== dv/glove_display_cases.txt ====
// columns: z byte, open_index, open_ring, expected can_catch (all hex)
// one case per line
00 1 1 1
40 0 0 1
47 1 0 0
48 0 1 1
41 1 1 0
3F 0 0 0
FF 1 1 1
80 1 0 1
46 0 1 0
01 1 1 0
7A 0 0 1
20 1 1 0

// ==== verilog.f ====
+incdir+common
common/glove_display_pkg.sv
hw/glove_frontend.sv
display/disp_clock_gen.sv
display/disp_sequencer.sv
display/disp_char_font.sv
hw/glove_display_top.sv
dv/tb_clock.sv
dv/glove_display_tb.sv

// ==== Bender.yml ====
package:
  name: glove_display

sources:
  - include_dirs:
      - common
    files:
      - common/glove_display_pkg.sv
      - hw/glove_frontend.sv
      - display/disp_clock_gen.sv
      - display/disp_sequencer.sv
      - display/disp_char_font.sv
      - hw/glove_display_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - dv/tb_clock.sv
      - dv/glove_display_tb.sv

// ==== dv/glove_display_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "glove_display_cfg.svh"

module glove_display_tb;

   localparam int file_cases = 12;
   localparam int random_cases = 4;
   localparam int total_cases = file_cases + random_cases;
   localparam int adc_half_cycles = `ADC_DIV_TERMINAL + 1;
   localparam int step_cycles = 2 * (`DISP_DIV_TERMINAL + 1);
   localparam longint watchdog_ns = longint'(total_cases + 3) * 700 * step_cycles * 40;

   logic clock_27mhz;
   logic reset;
   logic [7:0] z_data;
   logic open_index;
   logic open_ring;
   logic adc_clock;
   logic can_catch;
   logic disp_blank;
   logic disp_clock;
   logic disp_rs;
   logic disp_ce_b;
   logic disp_reset_b;
   logic disp_data_out;

   logic [7:0] case_mem [0:4*file_cases-1];
   logic [7:0] case_z [0:total_cases-1];
   logic case_open_index [0:total_cases-1];
   logic case_open_ring [0:total_cases-1];
   logic case_catch [0:total_cases-1];

   int mismatch_count = 0;
   int protocol_count = 0;
   int check_count = 0;

   // serial stream capture
   logic [639:0] seg_bits = '0;
   int seg_len = 0;
   logic seg_rs = 1'b0;
   logic seg_rs_mixed = 1'b0;
   int seg_count = 0;
   logic [639:0] frame_bits = '0;
   int frames_done = 0;

   // cycle level monitor state
   int adc_count;
   int dclk_count;
   int since_reset;
   logic adc_prev;
   logic dclk_prev;
   logic dclk_fall;
   logic fall_seen;
   logic [3:0] serial_prev;

   tb_clock clock_i
   (
      .clock_27mhz (clock_27mhz)
   );

   glove_display_top dut_i
   (
      .clock_27mhz   (clock_27mhz),
      .reset         (reset),
      .z_data        (z_data),
      .open_index    (open_index),
      .open_ring     (open_ring),
      .adc_clock     (adc_clock),
      .can_catch     (can_catch),
      .disp_blank    (disp_blank),
      .disp_clock    (disp_clock),
      .disp_rs       (disp_rs),
      .disp_ce_b     (disp_ce_b),
      .disp_reset_b  (disp_reset_b),
      .disp_data_out (disp_data_out)
   );

   ////////////////////////////////////////////////////////////
   // reference model
   ////////////////////////////////////////////////////////////

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] s;
      s = x ^ (x << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   function automatic logic catch_rule(input logic [7:0] z);
      return (z > `CATCH_Z_LIMIT) || (z == 8'h00) || (z == `CATCH_Z_REST);
   endfunction

   // 5x8 hex font, one byte per column, left column first
   function automatic logic [39:0] hex_glyph(input logic [3:0] digit);
      logic [39:0] g;
      case (digit)
         4'h0: g = 40'h3E_51_49_45_3E;
         4'h1: g = 40'h00_42_7F_40_00;
         4'h2: g = 40'h62_51_49_49_46;
         4'h3: g = 40'h22_41_49_49_36;
         4'h4: g = 40'h18_14_12_7F_10;
         4'h5: g = 40'h27_45_45_45_39;
         4'h6: g = 40'h3C_4A_49_49_30;
         4'h7: g = 40'h01_71_09_05_03;
         4'h8: g = 40'h36_49_49_49_36;
         4'h9: g = 40'h06_49_49_29_1E;
         4'hA: g = 40'h7E_09_09_09_7E;
         4'hB: g = 40'h7F_49_49_49_36;
         4'hC: g = 40'h3E_41_41_41_22;
         4'hD: g = 40'h7F_41_41_41_3E;
         4'hE: g = 40'h7F_49_49_49_41;
         default: g = 40'h7F_09_09_09_01;
      endcase
      return g;
   endfunction

   // first bit on the wire ends up in bit 639
   function automatic logic [639:0] expected_frame(input logic [63:0] word);
      logic [639:0] f;
      f = '0;
      for (int d = 0; d < 16; d++)
         f[40*d +: 40] = hex_glyph(word[4*d +: 4]);
      return f;
   endfunction

   ////////////////////////////////////////////////////////////
   // serial stream monitor
   ////////////////////////////////////////////////////////////

   task automatic close_segment();
      check_count++;
      if (seg_count == 0)
      begin
         if (seg_len != `DOT_REG_BITS || seg_rs !== 1'b0 || seg_rs_mixed)
         begin
            protocol_count++;
            $display("Error: clear phase sent %0d bits with rs %b", seg_len, seg_rs);
         end
         else if (seg_bits !== '0)
         begin
            mismatch_count++;
            $display("Mismatch clear_bits expected 0 actual %h", seg_bits);
         end
      end
      else if (seg_count == 1)
      begin
         if (seg_len != `CTRL_REG_BITS || seg_rs !== 1'b1 || seg_rs_mixed)
         begin
            protocol_count++;
            $display("Error: control load sent %0d bits with rs %b", seg_len, seg_rs);
         end
         else if (seg_bits[31:0] !== `CTRL_REG_INIT)
         begin
            mismatch_count++;
            $display("Mismatch control_word expected %h actual %h",
                     `CTRL_REG_INIT, seg_bits[31:0]);
         end
      end
      else
      begin
         if (seg_len != `DOT_REG_BITS || seg_rs !== 1'b0 || seg_rs_mixed)
         begin
            protocol_count++;
            $display("Error: digit frame sent %0d bits with rs %b", seg_len, seg_rs);
         end
         frame_bits = seg_bits;
         frames_done++;
      end
      seg_count++;
      seg_len = 0;
      seg_rs_mixed = 1'b0;
   endtask

   // display samples on the rising edge of its clock
   always @(posedge disp_clock)
   begin
      if (!reset)
      begin
         if (disp_ce_b === 1'b0)
         begin
            if (disp_reset_b !== 1'b1)
            begin
               protocol_count++;
               $display("Error: serial bit clocked while the display is in reset");
            end
            if (seg_len == 0)
               seg_rs = disp_rs;
            else if (disp_rs !== seg_rs)
               seg_rs_mixed = 1'b1;
            seg_bits = {seg_bits[638:0], disp_data_out};
            seg_len++;
         end
         else if (seg_len != 0)
            close_segment();
      end
   end

   ////////////////////////////////////////////////////////////
   // cycle level checks
   ////////////////////////////////////////////////////////////

   always @(posedge clock_27mhz)
   begin
      if (reset)
      begin
         adc_count = 0;
         dclk_count = 0;
         since_reset = 0;
         fall_seen = 1'b0;
         adc_prev = adc_clock;
         dclk_prev = disp_clock;
         serial_prev = {disp_data_out, disp_rs, disp_ce_b, disp_reset_b};
      end
      else
      begin
         since_reset++;
         if (adc_clock !== adc_prev)
         begin
            check_count++;
            if (adc_count != adc_half_cycles)
            begin
               mismatch_count++;
               $display("Mismatch adc_clock_half_period expected %0d actual %0d",
                        adc_half_cycles, adc_count);
            end
            adc_count = 1;
         end
         else
            adc_count++;

         // one serial bit per display clock period
         dclk_fall = (dclk_prev === 1'b1) && (disp_clock === 1'b0);
         dclk_count++;
         if (dclk_fall)
         begin
            if (fall_seen && dclk_count != step_cycles)
            begin
               mismatch_count++;
               $display("Mismatch bit_length expected %0d actual %0d",
                        step_cycles, dclk_count);
            end
            fall_seen = 1'b1;
            dclk_count = 0;
         end

         if ({disp_data_out, disp_rs, disp_ce_b, disp_reset_b} !== serial_prev && !dclk_fall)
         begin
            protocol_count++;
            $display("Error: serial outputs changed away from a display clock fall");
         end

         if (disp_reset_b === 1'b1 && serial_prev[0] === 1'b0)
         begin
            check_count++;
            if (since_reset < `DISP_RESET_CYCLES + step_cycles)
            begin
               protocol_count++;
               $display("Error: display left reset after only %0d cycles", since_reset);
            end
         end
         else if (disp_reset_b === 1'b0 && serial_prev[0] === 1'b1)
         begin
            protocol_count++;
            $display("Error: display went back into reset");
         end

         if (disp_blank !== 1'b0)
         begin
            protocol_count++;
            $display("Error: display blanked");
         end

         adc_prev = adc_clock;
         dclk_prev = disp_clock;
         serial_prev = {disp_data_out, disp_rs, disp_ce_b, disp_reset_b};
      end
   end

   ////////////////////////////////////////////////////////////
   // run control
   ////////////////////////////////////////////////////////////

   task automatic finish_run();
      $display("checks %0d, mismatches %0d, other errors %0d",
               check_count, mismatch_count, protocol_count);
      if (mismatch_count == 0 && protocol_count == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   endtask

   initial
   begin
      #(watchdog_ns);
      protocol_count++;
      $display("Error: timeout, the display stream stopped before all cases were checked");
      finish_run();
   end

   initial
   begin
      logic [31:0] rng;
      logic [63:0] word;
      logic [639:0] exp_frame;
      int target;
      int bad;
      reset = 1'b1;
      z_data = 8'h00;
      open_index = 1'b0;
      open_ring = 1'b0;

      $readmemh("dv/glove_display_cases.txt", case_mem);
      for (int i = 0; i < file_cases; i++)
      begin
         case_z[i] = case_mem[4*i];
         case_open_index[i] = case_mem[4*i+1][0];
         case_open_ring[i] = case_mem[4*i+2][0];
         case_catch[i] = case_mem[4*i+3][0];
      end
      rng = 32'd6;
      for (int i = file_cases; i < total_cases; i++)
      begin
         rng = xorshift32(rng);
         case_z[i] = rng[7:0];
         case_open_index[i] = rng[8];
         case_open_ring[i] = rng[9];
         case_catch[i] = catch_rule(rng[7:0]);
      end

      repeat (2) @(posedge clock_27mhz);
      @(negedge clock_27mhz);
      reset = 1'b0;

      for (int i = 0; i < total_cases; i++)
      begin
         // apply right after a latch so the next frame sees the new word
         @(negedge clock_27mhz);
         z_data = case_z[i];
         open_index = case_open_index[i];
         open_ring = case_open_ring[i];
         target = frames_done + 1;

         @(negedge clock_27mhz);
         check_count++;
         if (can_catch !== case_catch[i])
         begin
            mismatch_count++;
            $display("Mismatch case %0d can_catch expected %b actual %b",
                     i, case_catch[i], can_catch);
         end

         wait (frames_done >= target);
         word = {3'b000, case_catch[i], 51'd0, case_open_index[i] & case_open_ring[i],
                 case_z[i]};
         exp_frame = expected_frame(word);
         check_count++;
         if (frame_bits !== exp_frame)
         begin
            mismatch_count++;
            bad = -1;
            for (int d = 15; d >= 0; d--)
               if (bad < 0 && frame_bits[40*d +: 40] !== exp_frame[40*d +: 40])
                  bad = d;
            if (bad < 0)
               bad = 0;
            $display("Mismatch case %0d frame digit %0d expected %h actual %h",
                     i, bad, exp_frame[40*bad +: 40], frame_bits[40*bad +: 40]);
         end
      end

      finish_run();
   end

endmodule

`default_nettype wire

// ==== dv/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock
#(
   parameter int half_period_ns = 20
)
(
   output logic clock_27mhz
);

   // free-running clock, 40 ns period by default
   initial
   begin
      clock_27mhz = 1'b0;
      forever
         #(half_period_ns) clock_27mhz = ~clock_27mhz;
   end

endmodule

`default_nettype wire

// ==== hw/glove_display_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module glove_display_top
(
   input  logic       clock_27mhz,
   input  logic       reset,
   input  logic [7:0] z_data,
   input  logic       open_index,
   input  logic       open_ring,
   output logic       adc_clock,
   output logic       can_catch,
   output logic       disp_blank,
   output logic       disp_clock,
   output logic       disp_rs,
   output logic       disp_ce_b,
   output logic       disp_reset_b,
   output logic       disp_data_out
);

   glove_display_pkg::hex_word_t disp_word;
   glove_display_pkg::char_index_t char_index;
   glove_display_pkg::dot_index_t dot_index;
   logic step;
   logic hold;
   logic glyph_dot;

   // display never blanked
   assign disp_blank = 1'b0;

   ////////////////////////////////////////////////////////////
   // glove side
   ////////////////////////////////////////////////////////////

   glove_frontend frontend_i
   (
      .clock_27mhz (clock_27mhz),
      .reset       (reset),
      .z_data      (z_data),
      .open_index  (open_index),
      .open_ring   (open_ring),
      .adc_clock   (adc_clock),
      .can_catch   (can_catch),
      .disp_word   (disp_word)
   );

   ////////////////////////////////////////////////////////////
   // display side
   ////////////////////////////////////////////////////////////

   disp_clock_gen clock_gen_i
   (
      .clock_27mhz (clock_27mhz),
      .reset       (reset),
      .disp_clock  (disp_clock),
      .step        (step),
      .hold        (hold)
   );

   disp_sequencer sequencer_i
   (
      .clock_27mhz   (clock_27mhz),
      .reset         (reset),
      .step          (step),
      .hold          (hold),
      .glyph_dot     (glyph_dot),
      .char_index    (char_index),
      .dot_index     (dot_index),
      .disp_rs       (disp_rs),
      .disp_ce_b     (disp_ce_b),
      .disp_reset_b  (disp_reset_b),
      .disp_data_out (disp_data_out)
   );

   disp_char_font font_i
   (
      .disp_word  (disp_word),
      .char_index (char_index),
      .dot_index  (dot_index),
      .glyph_dot  (glyph_dot)
   );

endmodule

`default_nettype wire

// ==== display/disp_char_font.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "glove_display_cfg.svh"

module disp_char_font
(
   input  glove_display_pkg::hex_word_t   disp_word,
   input  glove_display_pkg::char_index_t char_index,
   input  glove_display_pkg::dot_index_t  dot_index,
   output logic                           glyph_dot
);

   logic [3:0] nibble;
   glove_display_pkg::glyph_t glyph;

   ////////////////////////////////////////////////////////////
   // 5x8 hex font, one byte per column
   ////////////////////////////////////////////////////////////

   function automatic glove_display_pkg::glyph_t glyph_of(input logic [3:0] digit);
      glove_display_pkg::glyph_t g;
      case (digit)
         4'h0: g = 40'h3E_51_49_45_3E;
         4'h1: g = 40'h00_42_7F_40_00;
         4'h2: g = 40'h62_51_49_49_46;
         4'h3: g = 40'h22_41_49_49_36;
         4'h4: g = 40'h18_14_12_7F_10;
         4'h5: g = 40'h27_45_45_45_39;
         4'h6: g = 40'h3C_4A_49_49_30;
         4'h7: g = 40'h01_71_09_05_03;
         4'h8: g = 40'h36_49_49_49_36;
         4'h9: g = 40'h06_49_49_29_1E;
         4'hA: g = 40'h7E_09_09_09_7E;
         4'hB: g = 40'h7F_49_49_49_36;
         4'hC: g = 40'h3E_41_41_41_22;
         4'hD: g = 40'h7F_41_41_41_3E;
         4'hE: g = 40'h7F_49_49_49_41;
         default: g = 40'h7F_09_09_09_01;
      endcase
      return g;
   endfunction

   // digit 15 sits in the top nibble
   assign nibble = disp_word[{char_index, 2'b00} +: 4];

   assign glyph = glyph_of(nibble);

   // dot counter runs past one glyph during the clear phase
   assign glyph_dot = (dot_index < 10'(`CHAR_DOTS)) ? glyph[dot_index[5:0]] : 1'b0;

endmodule

`default_nettype wire

// ==== display/disp_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "glove_display_cfg.svh"

module disp_sequencer
(
   input  logic                           clock_27mhz,
   input  logic                           reset,
   input  logic                           step,
   input  logic                           hold,
   input  logic                           glyph_dot,
   output glove_display_pkg::char_index_t char_index,
   output glove_display_pkg::dot_index_t  dot_index,
   output logic                           disp_rs,
   output logic                           disp_ce_b,
   output logic                           disp_reset_b,
   output logic                           disp_data_out
);

   glove_display_pkg::disp_state_t state;
   logic [`CTRL_REG_BITS-1:0] ctrl_shift;

   ////////////////////////////////////////////////////////////
   // display control FSM
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clock_27mhz)
   begin
      if (reset || hold)
      begin
         state <= glove_display_pkg::RESET_DISP;
         char_index <= 4'(`NUM_CHARS - 1);
         dot_index <= '0;
         ctrl_shift <= `CTRL_REG_INIT;
         disp_rs <= 1'b0;
         disp_ce_b <= 1'b1;
         disp_reset_b <= 1'b0;
         disp_data_out <= 1'b0;
      end
      else if (step)
      begin
         case (state)
            glove_display_pkg::RESET_DISP:
            begin
               // one step with the display held in reset
               disp_data_out <= 1'b0;
               disp_rs <= 1'b0;
               disp_ce_b <= 1'b1;
               disp_reset_b <= 1'b0;
               dot_index <= '0;
               state <= glove_display_pkg::END_RESET;
            end
            glove_display_pkg::END_RESET:
            begin
               disp_reset_b <= 1'b1;
               state <= glove_display_pkg::CLEAR_DOTS;
            end
            glove_display_pkg::CLEAR_DOTS:
            begin
               // zero every dot of the dot register
               disp_ce_b <= 1'b0;
               disp_data_out <= 1'b0;
               if (dot_index == 10'(`DOT_REG_BITS - 1))
                  state <= glove_display_pkg::LATCH_CLEAR;
               else
                  dot_index <= dot_index + 10'd1;
            end
            glove_display_pkg::LATCH_CLEAR:
            begin
               // control register next
               disp_ce_b <= 1'b1;
               disp_rs <= 1'b1;
               dot_index <= 10'(`CTRL_REG_BITS - 1);
               state <= glove_display_pkg::LOAD_CONTROL;
            end
            glove_display_pkg::LOAD_CONTROL:
            begin
               disp_ce_b <= 1'b0;
               disp_data_out <= ctrl_shift[`CTRL_REG_BITS-1];
               ctrl_shift <= {ctrl_shift[`CTRL_REG_BITS-2:0], 1'b0};
               if (dot_index == 10'd0)
                  state <= glove_display_pkg::LATCH_DATA;
               else
                  dot_index <= dot_index - 10'd1;
            end
            glove_display_pkg::LATCH_DATA:
            begin
               // latch and restart from the leftmost digit
               disp_ce_b <= 1'b1;
               disp_rs <= 1'b0;
               dot_index <= 10'(`CHAR_DOTS - 1);
               char_index <= 4'(`NUM_CHARS - 1);
               state <= glove_display_pkg::LOAD_DIGITS;
            end
            glove_display_pkg::LOAD_DIGITS:
            begin
               disp_ce_b <= 1'b0;
               disp_data_out <= glyph_dot;
               if (dot_index != 10'd0)
                  dot_index <= dot_index - 10'd1;
               else if (char_index == 4'd0)
                  state <= glove_display_pkg::LATCH_DATA;
               else
               begin
                  char_index <= char_index - 4'd1;
                  dot_index <= 10'(`CHAR_DOTS - 1);
               end
            end
            default:
               state <= glove_display_pkg::RESET_DISP;
         endcase
      end
   end

   // chip enable stays off while the display is in reset
   a_ce_in_reset: assert property (@(posedge clock_27mhz) disable iff (reset)
      !disp_reset_b |-> disp_ce_b);

   a_dot_range: assert property (@(posedge clock_27mhz) disable iff (reset)
      dot_index <= 10'(`DOT_REG_BITS - 1));

endmodule

`default_nettype wire

// ==== display/disp_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "glove_display_cfg.svh"

module disp_clock_gen
(
   input  logic clock_27mhz,
   input  logic reset,
   output logic disp_clock,
   output logic step,
   output logic hold
);

   logic [4:0] div_count;
   logic div_level;
   logic [6:0] hold_count;

   ////////////////////////////////////////////////////////////
   // display clock divider
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clock_27mhz)
   begin
      if (reset)
      begin
         div_count <= '0;
         div_level <= 1'b0;
      end
      else if (div_count == 5'(`DISP_DIV_TERMINAL))
      begin
         div_count <= '0;
         div_level <= ~div_level;
      end
      else
         div_count <= div_count + 5'd1;
   end

   // sequencer moves on the same edge the level goes high
   assign step = (div_count == 5'(`DISP_DIV_TERMINAL)) && !div_level;

   // display samples on the opposite edge
   assign disp_clock = ~div_level;

   // startup hold
   always_ff @(posedge clock_27mhz)
   begin
      if (reset)
         hold_count <= 7'(`DISP_RESET_CYCLES);
      else if (hold_count != 7'd0)
         hold_count <= hold_count - 7'd1;
   end

   assign hold = (hold_count != 7'd0);

   a_step_single: assert property (@(posedge clock_27mhz) disable iff (reset)
      step |=> !step);

endmodule

`default_nettype wire

// ==== hw/glove_frontend.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "glove_display_cfg.svh"

module glove_frontend
(
   input  logic                            clock_27mhz,
   input  logic                            reset,
   input  glove_display_pkg::sensor_byte_t z_data,
   input  logic                            open_index,
   input  logic                            open_ring,
   output logic                            adc_clock,
   output logic                            can_catch,
   output glove_display_pkg::hex_word_t    disp_word
);

   logic [4:0] adc_count;
   logic catch_next;
   logic hand_open;
   glove_display_pkg::sensor_byte_t z_q;
   logic open_q;

   ////////////////////////////////////////////////////////////
   // converter clock divider
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clock_27mhz)
   begin
      if (reset)
      begin
         adc_count <= '0;
         adc_clock <= 1'b0;
      end
      else if (adc_count == 5'(`ADC_DIV_TERMINAL))
      begin
         adc_count <= '0;
         adc_clock <= ~adc_clock;
      end
      else
         adc_count <= adc_count + 5'd1;
   end

   ////////////////////////////////////////////////////////////
   // catch decision and display word
   ////////////////////////////////////////////////////////////

   // hand counts as open only with both fingers open
   assign hand_open = open_index & open_ring;

   // glove held steady, resting or above the limit
   assign catch_next = (z_data > `CATCH_Z_LIMIT) || (z_data == 8'h00) ||
                       (z_data == `CATCH_Z_REST);

   always_ff @(posedge clock_27mhz)
   begin
      if (reset)
         can_catch <= 1'b1;
      else
         can_catch <= catch_next;
   end

   always_ff @(posedge clock_27mhz)
   begin
      z_q <= z_data;
      open_q <= hand_open;
   end

   // catch flag on the leftmost digit, open flag and z on the right
   assign disp_word = {3'b000, can_catch, 51'd0, open_q, z_q};

   a_adc_toggle: assert property (@(posedge clock_27mhz) disable iff (reset)
      $changed(adc_clock) |-> $past(reset) || ($past(adc_count) == 5'(`ADC_DIV_TERMINAL)));

endmodule

`default_nettype wire

// ==== common/glove_display_pkg.sv ====
`default_nettype none

package glove_display_pkg;

   ////////////////////////////////////////////////////////////
   // glove sensor data
   ////////////////////////////////////////////////////////////

   // one accelerometer axis sample
   typedef logic [7:0] sensor_byte_t;

   ////////////////////////////////////////////////////////////
   // dot-matrix display data
   ////////////////////////////////////////////////////////////

   // sixteen hex digits, digit 15 in the top nibble
   typedef logic [63:0] hex_word_t;

   // five columns of eight dots, msb goes out first
   typedef logic [39:0] glyph_t;

   // digit position on the display
   typedef logic [3:0] char_index_t;

   // dot counter, wide enough for the full 640-dot clear
   typedef logic [9:0] dot_index_t;

   // sequencer phases
   typedef enum logic [2:0]
   {
      RESET_DISP,
      END_RESET,
      CLEAR_DOTS,
      LATCH_CLEAR,
      LOAD_CONTROL,
      LATCH_DATA,
      LOAD_DIGITS
   } disp_state_t;

endpackage

`default_nettype wire

// ==== common/glove_display_cfg.svh ====
`ifndef GLOVE_DISPLAY_CFG_SVH
`define GLOVE_DISPLAY_CFG_SVH

// converter clock toggles after ADC_DIV_TERMINAL + 1 cycles
`define ADC_DIV_TERMINAL 16

// z-axis catch thresholds
`define CATCH_Z_LIMIT 8'h47
`define CATCH_Z_REST 8'h40

// display clock level toggles after DISP_DIV_TERMINAL + 1 cycles
`define DISP_DIV_TERMINAL 26

// startup hold of the display logic
`define DISP_RESET_CYCLES 100

// display register geometry
`define DOT_REG_BITS 640
`define CTRL_REG_BITS 32
`define CHAR_DOTS 40
`define NUM_CHARS 16

// brightness and peak current setting for all four banks
`define CTRL_REG_INIT 32'h7F7F7F7F

`endif
